// ==== alu.f ====
+incdir+.
alu_ops_pkg.sv
alu_ctrl_pkg.sv
alu_logic_unit.sv
alu_shifter.sv
booth_multiplier.sv
restoring_divider.sv
alu_control.sv
alu_top.sv
tb_clock_gen.sv
alu_tb.sv

// ==== alu_control.sv ====
`timescale 1ns/1ns

module alu_control (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      start,
	input  alu_ctrl_pkg::alu_req_t    req,
	input  alu_ops_pkg::word_t        logic_y,
	input  alu_ops_pkg::word_t        shift_y,
	input  logic                      mul_done,
	input  alu_ctrl_pkg::alu_result_t mul_p,
	input  logic                      div_done,
	input  alu_ctrl_pkg::alu_result_t div_q,
	output logic                      mul_go,
	output logic                      div_go,
	output alu_ctrl_pkg::alu_result_t z,
	output logic                      done,
	output logic                      busy
);
	import alu_ops_pkg::*;
	import alu_ctrl_pkg::*;

	ctrl_state_e state;
	logic        accept;   // Start taken, no multi-cycle op in flight
	logic        is_logic;
	logic        is_shift;
	logic        is_mul;
	logic        is_div;
	alu_result_t single_z;

	always_comb begin
		is_logic = 1'b0;
		is_shift = 1'b0;
		is_mul   = 1'b0;
		is_div   = 1'b0;
		case (req.op)
			op_and, op_or, op_add, op_sub, op_neg, op_not: is_logic = 1'b1;
			op_shr, op_shra, op_shl, op_ror, op_rol:      is_shift = 1'b1;
			op_mul:  is_mul = 1'b1;
			op_div:  is_div = 1'b1;
			default: is_logic = 1'b0; // Illegal opcode, no class
		endcase
	end

	// Single-cycle result, illegal opcodes leave it zero
	always_comb begin
		single_z = '0;
		if (is_logic)
			single_z.lo = logic_y;
		else if (is_shift)
			single_z.lo = shift_y;
	end

	// st_done behaves as idle so back-to-back starts are taken
	assign accept = start && (state == st_idle || state == st_done);
	assign mul_go = accept && is_mul;
	assign div_go = accept && is_div;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= st_idle;
			z     <= '0;
		end else begin
			case (state)
				st_idle, st_done: begin
					if (!accept)
						state <= st_idle;
					else if (is_mul)
						state <= st_mul;
					else if (is_div)
						state <= st_div;
					else begin
						state <= st_done;
						z     <= single_z;
					end
				end
				st_mul: begin
					if (mul_done) begin
						state <= st_done;
						z     <= mul_p;
					end
				end
				st_div: begin
					if (div_done) begin
						state <= st_done;
						z     <= div_q;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign done = (state == st_done);
	assign busy = (state == st_mul) || (state == st_div); // Drops as done rises

endmodule

// ==== alu_ctrl_pkg.sv ====
package alu_ctrl_pkg;

	// One operation request, 69 bits
	typedef struct packed {
		alu_ops_pkg::alu_op_e op;
		alu_ops_pkg::word_t   a;
		alu_ops_pkg::word_t   b;
	} alu_req_t;

	// 64-bit result, hi is zero for 32-bit operations
	typedef struct packed {
		alu_ops_pkg::word_t hi; // Remainder for divide
		alu_ops_pkg::word_t lo; // Quotient for divide
	} alu_result_t;

	typedef enum logic [1:0] {
		st_idle,
		st_mul,  // Waiting on the multiplier
		st_div,  // Waiting on the divider
		st_done  // Result valid, done is high
	} ctrl_state_e;

endpackage

// ==== alu_logic_unit.sv ====
`timescale 1ns/1ns

module alu_logic_unit (
	input  alu_ctrl_pkg::alu_req_t req,
	output alu_ops_pkg::word_t     y
);
	import alu_ops_pkg::*;

	always_comb begin
		case (req.op)
			op_and: begin
				y = req.a & req.b;
			end
			op_or: begin
				y = req.a | req.b;
			end
			op_add: begin
				y = req.a + req.b; // Carry out is dropped
			end
			op_sub: begin
				y = req.a - req.b;
			end
			op_neg: begin
				y = ~req.a + 1'b1; // Two's complement of a
			end
			op_not: begin
				y = ~req.a;
			end
			default: begin
				y = '0; // Not a logic or arithmetic opcode
			end
		endcase
	end

endmodule

// ==== alu_ops_pkg.sv ====
`include "alu_settings.svh"

package alu_ops_pkg;

	typedef logic [`ALU_WIDTH-1:0] word_t; // One operand or half result

	typedef logic [`ALU_SHAMT_BITS-1:0] shamt_t; // Low bits of b

	// Step counter of the multi-cycle units, holds 0 up to ALU_ITER
	typedef logic [$clog2(`ALU_ITER+1)-1:0] iter_cnt_t;

	// Encodings follow the CPU instruction set
	typedef enum logic [`ALU_OP_BITS-1:0] {
		op_add  = 5'd3,
		op_sub  = 5'd4,
		op_and  = 5'd5,
		op_or   = 5'd6,
		op_ror  = 5'd7,
		op_rol  = 5'd8,
		op_shr  = 5'd9,
		op_shra = 5'd10,
		op_shl  = 5'd11,
		op_div  = 5'd15,
		op_mul  = 5'd16,
		op_neg  = 5'd17,
		op_not  = 5'd18
	} alu_op_e;

endpackage

// ==== alu_settings.svh ====
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Datapath operand width, also the width of each result half
`define ALU_WIDTH 32

// Opcode width, shared with the CPU decoder encoding
`define ALU_OP_BITS 5

// Shift and rotate amount comes from this many low bits of b
`define ALU_SHAMT_BITS 5

// Step cycles of the sequential multiplier and divider
`define ALU_ITER 32

`endif

// ==== alu_shifter.sv ====
`timescale 1ns/1ns
`include "alu_settings.svh"

module alu_shifter (
	input  alu_ctrl_pkg::alu_req_t req,
	output alu_ops_pkg::word_t     y
);
	import alu_ops_pkg::*;

	shamt_t                  sh;
	logic [2*`ALU_WIDTH-1:0] ror_dw; // a twice over, shifted right
	logic [2*`ALU_WIDTH-1:0] rol_dw; // a twice over, shifted left

	assign sh = req.b[`ALU_SHAMT_BITS-1:0];

	// Rotates fall out of shifting a doubled copy of a
	assign ror_dw = {req.a, req.a} >> sh;
	assign rol_dw = {req.a, req.a} << sh;

	always_comb begin
		case (req.op)
			op_shr:  y = req.a >> sh;
			op_shra: y = word_t'($signed(req.a) >>> sh); // Sign bit fills from the top
			op_shl:  y = req.a << sh;
			op_ror:  y = ror_dw[`ALU_WIDTH-1:0];
			op_rol:  y = rol_dw[2*`ALU_WIDTH-1:`ALU_WIDTH];
			default: y = '0;
		endcase
	end

endmodule

// ==== alu_tb.sv ====
`timescale 1ns/1ns
`include "alu_settings.svh"

module alu_tb;
	import alu_ops_pkg::*;
	import alu_ctrl_pkg::*;

	localparam int clk_period      = 10;
	localparam int num_ops         = 110; // Upper bound on operations issued below
	localparam int watchdog_cycles = 2 * num_ops * 34 + 4;

	logic        clock;
	logic        rst_n;
	logic        start;
	alu_req_t    req;
	alu_result_t z;
	logic        done;
	logic        busy;

	logic        launch;               // Start that the DUT must accept
	string       test_name;
	alu_result_t exp_z;
	int          exp_latency;
	int          since_start = 0;      // Clock edges since the accepted start
	int          launches    = 0;
	int          done_pulses = 0;
	logic [31:0] lfsr_state  = 32'hc8e7c07e;

	tb_clock_gen tb_clock_gen_i (
		.clock (clock),
		.rst_n (rst_n)
	);

	alu_top alu_top_i (
		.clock (clock),
		.rst_n (rst_n),
		.start (start),
		.req   (req),
		.z     (z),
		.done  (done),
		.busy  (busy)
	);

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic word_t rand_bits(input int n);
		word_t w;
		int    i;
		w = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			w          = {w[`ALU_WIDTH-2:0], lfsr_state[0]};
		end
		return w;
	endfunction

	// Edges from the start edge to the edge that loads z
	function automatic int latency_of(input alu_op_e op);
		return (op == op_mul || op == op_div) ? `ALU_ITER + 1 : 0;
	endfunction

	function automatic alu_result_t expected_result(input alu_req_t r);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [63:0] wide;
		int                 s;
		alu_result_t        res;
		sa  = {{32{r.a[31]}}, r.a};
		sb  = {{32{r.b[31]}}, r.b};
		s   = r.b[4:0];
		res = '0;
		case (r.op)
			op_and:  res.lo = r.a & r.b;
			op_or:   res.lo = r.a | r.b;
			op_add:  res.lo = r.a + r.b;
			op_sub:  res.lo = r.a - r.b;
			op_neg:  res.lo = 32'd0 - r.a;
			op_not:  res.lo = r.a ^ 32'hffffffff;
			op_shr:  res.lo = r.a >> s;
			op_shra: begin
				wide   = sa >> s; // Sign copies in the upper half feed the low word
				res.lo = wide[31:0];
			end
			op_shl:  res.lo = r.a << s;
			op_ror:  res.lo = (r.a >> s) | (r.a << (32 - s));
			op_rol:  res.lo = (r.a << s) | (r.a >> (32 - s));
			op_mul:  res = sa * sb;
			op_div: begin
				if (r.b == 32'd0) begin
					res.lo = 32'hffffffff;
					res.hi = r.a;
				end else begin
					wide   = sa / sb; // 64 bits keep -2^31 / -1 exact
					res.lo = wide[31:0];
					wide   = sa % sb;
					res.hi = wide[31:0];
				end
			end
			default: res = '0;
		endcase
		return res;
	endfunction

	task automatic launch_op(input string name, input alu_op_e op, input word_t a,
			input word_t b);
		alu_req_t r;
		r = '{op: op, a: a, b: b};
		@(negedge clock);
		test_name   = name;
		req         = r;
		exp_z       = expected_result(r);
		exp_latency = latency_of(op);
		start       = 1'b1;
		launch      = 1'b1;
		launches++;
		@(negedge clock);
		start  = 1'b0;
		launch = 1'b0;
	endtask

	task automatic finish_op();
		int n;
		n = 0;
		while (!done) begin
			@(negedge clock);
			n++;
			if (n > `ALU_ITER + 8)
				abort_run($sformatf("done never came for %s", test_name));
		end
		@(negedge clock); // Let the checks see the done cycle
	endtask

	task automatic run_op(input string name, input alu_op_e op, input word_t a, input word_t b);
		launch_op(name, op, a, b);
		finish_op();
	endtask

	task automatic reset_and_illegal();
		word_t a;
		word_t b;
		@(negedge clock);
		assert (!done && !busy) else abort_run("done or busy is high right after reset");
		assert (z == '0)
			else abort_run($sformatf("ERROR reset: expected %h, actual %h", 64'h0, z));
		a = rand_bits(32);
		b = rand_bits(32);
		run_op("illegal opcode 0", alu_op_e'(5'd0), a, b);
		run_op("illegal opcode 31", alu_op_e'(5'd31), b, a);
	endtask

	task automatic logic_ops();
		alu_op_e ops [6];
		word_t   ca [3];
		word_t   cb [3];
		word_t   a;
		word_t   b;
		int      i;
		int      j;
		ops = '{op_and, op_or, op_add, op_sub, op_neg, op_not};
		ca  = '{32'h0, 32'hffffffff, 32'h80000000};
		cb  = '{32'hffffffff, 32'h80000000, 32'h0};
		for (i = 0; i < 6; i++) begin
			for (j = 0; j < 3; j++)
				run_op($sformatf("logic %s", ops[i].name()), ops[i], ca[j], cb[j]);
			for (j = 0; j < 4; j++) begin
				a = rand_bits(32);
				b = rand_bits(32);
				run_op($sformatf("logic %s", ops[i].name()), ops[i], a, b);
			end
		end
	endtask

	task automatic shift_ops();
		alu_op_e ops [5];
		word_t   a;
		word_t   b;
		int      i;
		int      j;
		ops = '{op_shr, op_shra, op_shl, op_ror, op_rol};
		for (i = 0; i < 5; i++) begin
			for (j = 0; j < 6; j++) begin
				a = rand_bits(32);
				b = rand_bits(32); // Upper bits of b must not matter
				if (j == 0)
					b = b & ~32'h1f;
				else if (j == 1)
					b = b | 32'h1f;
				run_op($sformatf("shift %s", ops[i].name()), ops[i], a, b);
			end
		end
	endtask

	task automatic signed_multiply();
		word_t ca [5];
		word_t cb [5];
		word_t a;
		word_t b;
		int    i;
		ca = '{32'h80000000, 32'h80000000, 32'hffffffff, 32'h7fffffff, 32'h0};
		cb = '{32'h80000000, 32'hffffffff, 32'hffffffff, 32'h80000000, 32'hfffffffb};
		for (i = 0; i < 5; i++)
			run_op("mul corner", op_mul, ca[i], cb[i]);
		for (i = 0; i < 6; i++) begin
			a = rand_bits(32);
			b = rand_bits(32);
			run_op("mul random", op_mul, a, b);
		end
	endtask

	task automatic signed_divide();
		word_t ca [7];
		word_t cb [7];
		word_t a;
		word_t b;
		int    i;
		ca = '{32'hfffffff9, 32'h7, 32'hfffffff9, 32'h80000000, 32'h5, 32'hfffffffb,
			32'h80000000};
		cb = '{32'h2, 32'hfffffffe, 32'hfffffffe, 32'hffffffff, 32'h0, 32'h0, 32'h0};
		for (i = 0; i < 7; i++)
			run_op("div corner", op_div, ca[i], cb[i]);
		for (i = 0; i < 6; i++) begin
			a = rand_bits(32);
			b = (i % 2 == 0) ? rand_bits(12) : rand_bits(32); // Small divisors give big quotients
			if (rand_bits(1) == 1)
				b = -b;
			run_op("div random", op_div, a, b);
		end
	endtask

	task automatic start_while_busy(input string name, input alu_op_e op);
		word_t a;
		word_t b;
		a = rand_bits(32);
		b = rand_bits(16);
		launch_op(name, op, a, b);
		repeat (3) @(negedge clock);
		assert (busy) else abort_run($sformatf("busy is low while %s runs", name));
		start = 1'b1; // Same opcode with new operands, a restart would show
		req   = '{op: op, a: rand_bits(32), b: rand_bits(32)};
		@(negedge clock);
		start = 1'b0;
		finish_op();
	endtask

	always @(posedge clock) begin
		since_start <= launch ? 0 : since_start + 1;
		if (rst_n && done)
			done_pulses <= done_pulses + 1;
	end

	latency_check: assert property (@(posedge clock) disable iff (!rst_n)
			done |-> since_start == exp_latency)
		else abort_run($sformatf("ERROR %s latency: expected %0d, actual %0d",
			test_name, exp_latency, $sampled(since_start)));

	result_check: assert property (@(posedge clock) disable iff (!rst_n)
			done |-> z == exp_z)
		else abort_run($sformatf("ERROR %s: expected %h, actual %h",
			test_name, exp_z, $sampled(z)));

	initial begin
		#(watchdog_cycles * clk_period);
		abort_run("timeout, the tests did not finish in the allowed time");
	end

	initial begin
		start       = 1'b0;
		launch      = 1'b0;
		req         = '0;
		test_name   = "reset";
		exp_z       = '0;
		exp_latency = 1;
		wait (rst_n === 1'b1);
		reset_and_illegal();
		logic_ops();
		shift_ops();
		signed_multiply();
		signed_divide();
		start_while_busy("mul with start while busy", op_mul);
		start_while_busy("div with start while busy", op_div);
		if (done_pulses != launches)
			abort_run($sformatf("saw %0d done pulses for %0d operations", done_pulses, launches));
		else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// ==== alu_top.sv ====
`timescale 1ns/1ns

module alu_top (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      start,
	input  alu_ctrl_pkg::alu_req_t    req,
	output alu_ctrl_pkg::alu_result_t z,
	output logic                      done,
	output logic                      busy
);
	import alu_ops_pkg::*;
	import alu_ctrl_pkg::*;

	word_t       logic_y;
	word_t       shift_y;
	logic        mul_go;
	logic        mul_done;
	alu_result_t mul_z;
	logic        div_go;
	logic        div_done;
	alu_result_t div_z;

	alu_control alu_control_i (
		.clock    (clock),
		.rst_n    (rst_n),
		.start    (start),
		.req      (req),
		.logic_y  (logic_y),
		.shift_y  (shift_y),
		.mul_done (mul_done),
		.mul_p    (mul_z),
		.div_done (div_done),
		.div_q    (div_z),
		.mul_go   (mul_go),
		.div_go   (div_go),
		.z        (z),
		.done     (done),
		.busy     (busy)
	);

	alu_logic_unit alu_logic_unit_i (
		.req (req),
		.y   (logic_y)
	);

	alu_shifter alu_shifter_i (
		.req (req),
		.y   (shift_y)
	);

	// Operands are latched on the go edge, req may change afterwards
	booth_multiplier booth_multiplier_i (
		.clock (clock),
		.rst_n (rst_n),
		.go    (mul_go),
		.a     (req.a),
		.b     (req.b),
		.done  (mul_done),
		.p     (mul_z)
	);

	restoring_divider restoring_divider_i (
		.clock (clock),
		.rst_n (rst_n),
		.go    (div_go),
		.a     (req.a),
		.b     (req.b),
		.done  (div_done),
		.q     (div_z)
	);

endmodule

// ==== booth_multiplier.sv ====
`timescale 1ns/1ns
`include "alu_settings.svh"

module booth_multiplier (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      go,
	input  alu_ops_pkg::word_t        a,
	input  alu_ops_pkg::word_t        b,
	output logic                      done,
	output alu_ctrl_pkg::alu_result_t p
);
	import alu_ops_pkg::*;

	logic [`ALU_WIDTH:0] acc;       // Guard bit keeps a -2^31 multiplicand exact
	logic [`ALU_WIDTH:0] acc_sum;
	word_t               mcand;
	word_t               mplier;    // Low product word builds up here
	logic                mplier_q1; // Booth bit below the multiplier
	iter_cnt_t           cnt;
	logic                running;

	// Radix-2 recoding of the two lowest bits
	always_comb begin
		case ({mplier[0], mplier_q1})
			2'b01:   acc_sum = acc + {mcand[`ALU_WIDTH-1], mcand};
			2'b10:   acc_sum = acc - {mcand[`ALU_WIDTH-1], mcand};
			default: acc_sum = acc;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			running <= 1'b0;
			cnt     <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (go) begin
				running <= 1'b1;
				cnt     <= iter_cnt_t'(`ALU_ITER);
			end else if (running) begin
				cnt <= cnt - 1'b1;
				if (cnt == iter_cnt_t'(1)) begin // Last step
					running <= 1'b0;
					done    <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (go) begin
			acc       <= '0;
			mcand     <= a;
			mplier    <= b;
			mplier_q1 <= 1'b0;
		end else if (running) begin
			// Arithmetic shift right of {acc, mplier, mplier_q1}
			acc       <= {acc_sum[`ALU_WIDTH], acc_sum[`ALU_WIDTH:1]};
			mplier    <= {acc_sum[0], mplier[`ALU_WIDTH-1:1]};
			mplier_q1 <= mplier[0];
		end
	end

	assign p = '{hi: acc[`ALU_WIDTH-1:0], lo: mplier};

endmodule

// ==== restoring_divider.sv ====
`timescale 1ns/1ns
`include "alu_settings.svh"

module restoring_divider (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      go,
	input  alu_ops_pkg::word_t        a,
	input  alu_ops_pkg::word_t        b,
	output logic                      done,
	output alu_ctrl_pkg::alu_result_t q
);
	import alu_ops_pkg::*;

	word_t               rem;      // Partial remainder, magnitude
	word_t               quo;      // Dividend bits shift out, quotient bits shift in
	word_t               abs_b;
	logic [`ALU_WIDTH:0] rem_sh;
	logic                fits;     // Divisor goes into the shifted remainder
	logic                neg_a;
	logic                neg_q;
	logic                div_zero;
	word_t               quo_fix;
	word_t               rem_fix;
	iter_cnt_t           cnt;
	logic                running;

	assign rem_sh = {rem, quo[`ALU_WIDTH-1]};
	assign fits   = rem_sh >= {1'b0, abs_b};

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			running <= 1'b0;
			cnt     <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (go) begin
				running <= 1'b1;
				cnt     <= iter_cnt_t'(`ALU_ITER);
			end else if (running) begin
				cnt <= cnt - 1'b1;
				if (cnt == iter_cnt_t'(1)) begin
					running <= 1'b0;
					done    <= 1'b1;
				end
			end
		end
	end

	// With a zero divisor every step fits, so quo ends all ones and rem ends |a|
	always_ff @(posedge clock) begin
		if (go) begin
			rem      <= '0;
			quo      <= a[`ALU_WIDTH-1] ? -a : a;
			abs_b    <= b[`ALU_WIDTH-1] ? -b : b;
			neg_a    <= a[`ALU_WIDTH-1];
			neg_q    <= a[`ALU_WIDTH-1] ^ b[`ALU_WIDTH-1];
			div_zero <= (b == '0);
		end else if (running) begin
			rem <= fits ? word_t'(rem_sh - {1'b0, abs_b}) : rem_sh[`ALU_WIDTH-1:0];
			quo <= {quo[`ALU_WIDTH-2:0], fits};
		end
	end

	// Truncating division, remainder follows the dividend sign
	assign quo_fix = div_zero ? '1 : (neg_q ? -quo : quo);
	assign rem_fix = neg_a ? -rem : rem;

	assign q = '{hi: rem_fix, lo: quo_fix};

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ALU testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f alu.f --top-module alu_tb -Mdir obj_dir -o alu_sim

./obj_dir/alu_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi

echo "Simulation passed"
exit 0

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clock,
	output logic rst_n
);
	localparam int half_period  = 5; // 10 ns clock
	localparam int reset_cycles = 4;

	initial begin
		clock = 1'b0;
		forever #half_period clock = ~clock;
	end

	// Reset lifts on a falling edge, like the rest of the stimulus
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
	end

endmodule
